// ==== verif/rv_testdata.hex ====
// program words from address 0, then at word 0x40 the trace length,
// then trace entries of four words: pc instr rd data
@000
00500093 // addi x1, x0, 5
00308113 // addi x2, x1, 3
00208533 // add  x10, x1, x2
401101B3 // sub  x3, x2, x1
00F1C213 // xori x4, x3, 0xf
03126293 // ori  x5, x4, 0x31
00E2F313 // andi x6, x5, 0xe
0021A3B3 // slt  x7, x3, x2
12345437 // lui  x8, 0x12345
005444B3 // xor  x9, x8, x5
007365B3 // or   x11, x6, x7
0022F633 // and  x12, x5, x2
00708013 // addi x0, x1, 7
0000050B // unknown opcode, rd field x10
00A006B3 // add  x13, x0, x10
00208463 // beq  x1, x2, +8 not taken
00209463 // bne  x1, x2, +8 taken
7FF00513 // skipped
0011C463 // blt  x3, x1, +8 taken
00100513 // skipped
0030C463 // blt  x1, x3, +8 not taken
00318463 // beq  x3, x3, +8 taken
00200513 // skipped
0080076F // jal  x14, +8
00300513 // skipped
07100793 // addi x15, x0, 0x71
00078867 // jalr x16, 0(x15) to 0x70
00400513 // skipped
01070513 // addi x10, x14, 0x10
01050533 // add  x10, x10, x16
0000006F // jal  x0, 0
@040
0000001B
00000000 00500093 00000001 00000005
00000004 00308113 00000002 00000008
00000008 00208533 0000000A 0000000D
0000000C 401101B3 00000003 00000003
00000010 00F1C213 00000004 0000000C
00000014 03126293 00000005 0000003D
00000018 00E2F313 00000006 0000000C
0000001C 0021A3B3 00000007 00000001
00000020 12345437 00000008 12345000
00000024 005444B3 00000009 1234503D
00000028 007365B3 0000000B 0000000D
0000002C 0022F633 0000000C 00000008
00000030 00708013 00000000 00000000
00000034 0000050B 00000000 00000000
00000038 00A006B3 0000000D 0000000D
0000003C 00208463 00000000 00000000
00000040 00209463 00000000 00000000
00000048 0011C463 00000000 00000000
00000050 0030C463 00000000 00000000
00000054 00318463 00000000 00000000
0000005C 0080076F 0000000E 00000060
00000064 07100793 0000000F 00000071
00000068 00078867 00000010 0000006C
00000070 01070513 0000000A 00000070
00000074 01050533 0000000A 000000DC
00000078 0000006F 00000000 00000000
00000078 0000006F 00000000 00000000

// ==== tb.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/rv_core_top.sv
verif/tb_clock_gen.sv
verif/rv_core_assert.sv
verif/tb_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
./obj_dir/tb_sim | tee sim.log

grep -q "All tests passed" sim.log

// ==== verif/tb_top.sv ====
`timescale 1ns/1ns
`include "rv_defs.svh"

module tb_top;

    // program in words 0x00..0x3f then the trace count at 0x40 and the trace from 0x41
    localparam int MEM_WORDS   = 256;
    localparam int PROG_WORDS  = 64;
    localparam int COUNT_INDEX = 64;
    localparam int TRACE_BASE  = 65;
    localparam int WAIT_LIMIT  = 60;

    logic                     clk;
    logic                     reset_i;
    logic [`RV_ILEN-1:0]      sram_rdata_i;
    logic                     sram_data_valid_i;
    logic [`RV_XLEN-1:0]      sram_addr_o;
    logic                     sram_ren_o;
    logic                     commit_valid_o;
    logic [`RV_XLEN-1:0]      commit_pc_o;
    logic [`RV_ILEN-1:0]      commit_instr_o;
    logic [`RV_REG_IDX_W-1:0] commit_rd_o;
    logic [`RV_XLEN-1:0]      commit_data_o;
    logic [`RV_XLEN-1:0]      reg_a0_o;

    logic [31:0]         test_mem [MEM_WORDS];
    logic [7:0]          lfsr_q;
    logic                a0_pending;
    logic [`RV_XLEN-1:0] a0_expected;

    tb_clock_gen u_clock (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    rv_core_top uut (
        .clk               (clk),
        .reset_i           (reset_i),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .sram_addr_o       (sram_addr_o),
        .sram_ren_o        (sram_ren_o),
        .commit_valid_o    (commit_valid_o),
        .commit_pc_o       (commit_pc_o),
        .commit_instr_o    (commit_instr_o),
        .commit_rd_o       (commit_rd_o),
        .commit_data_o     (commit_data_o),
        .reg_a0_o          (reg_a0_o)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [`RV_XLEN-1:0] got,
                              input logic [`RV_XLEN-1:0] expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, expected);
            report_failure("value mismatch");
        end
    endtask

    task automatic check_reg_idx(input string name, input logic [`RV_REG_IDX_W-1:0] got,
                                 input logic [`RV_REG_IDX_W-1:0] expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%02h expected 0x%02h", name, got, expected);
            report_failure("register index mismatch");
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return state[0] ? ((state >> 1) ^ 8'hB8) : (state >> 1);
    endfunction

    task automatic draw_delay(output int delay);
        delay = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            delay  = (delay << 1) | int'(lfsr_q[0]);
        end
    endtask

    function automatic logic [`RV_ILEN-1:0] sram_word(input logic [`RV_XLEN-1:0] addr);
        if (addr < `RV_XLEN'(PROG_WORDS * 4)) begin
            return test_mem[addr[9:2]];
        end
        return addr ^ 32'hDEAD_BEEF;
    endfunction

    // sram model answering 0 to 3 cycles after the request is seen
    initial begin : sram_model
        int                  remaining;
        logic                busy;
        logic [`RV_XLEN-1:0] req_addr;
        sram_rdata_i      = '0;
        sram_data_valid_i = 1'b0;
        lfsr_q            = 8'd70;
        busy              = 1'b0;
        remaining         = 0;
        req_addr          = '0;
        forever begin
            @(posedge clk);
            #10;
            sram_data_valid_i = 1'b0;
            if (!busy && sram_ren_o) begin
                draw_delay(remaining);
                busy     = 1'b1;
                req_addr = sram_addr_o;
            end
            if (busy) begin
                if (remaining == 0) begin
                    sram_rdata_i      = sram_word(req_addr);
                    sram_data_valid_i = 1'b1;
                    busy              = 1'b0;
                end else begin
                    remaining--;
                end
            end
        end
    end

    // one negedge plus the pending a0 check
    task automatic next_cycle();
        @(negedge clk);
        if (a0_pending) begin
            check_word("reg_a0_o", reg_a0_o, a0_expected);
            a0_pending = 1'b0;
        end
    endtask

    task automatic wait_commit(input int index);
        int cycles;
        cycles = 0;
        next_cycle();
        while (!commit_valid_o && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!commit_valid_o) begin
            $display("no commit arrived for trace entry %0d", index);
            report_failure("timed out waiting for a commit");
        end
    endtask

    initial begin : main_seq
        int                  cycles;
        int                  count;
        int                  base;
        logic [`RV_XLEN-1:0] exp_data;
        a0_pending  = 1'b0;
        a0_expected = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            test_mem[i] = 32'hBAD0_0000 | i;
        end
        $readmemh("verif/rv_testdata.hex", test_mem);
        count = int'(test_mem[COUNT_INDEX]);

        @(posedge clk);
        cycles = 0;
        while (reset_i && cycles < 20) begin
            @(negedge clk);
            if (sram_ren_o || commit_valid_o) begin
                report_failure("fetch request or commit seen during reset");
            end
            cycles++;
        end
        if (reset_i) begin
            report_failure("reset was never released");
        end

        cycles = 0;
        while (!sram_ren_o && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!sram_ren_o) begin
            report_failure("no fetch request after reset");
        end
        check_word("sram_addr_o", sram_addr_o, `RV_RESET_PC);

        for (int i = 0; i < count; i++) begin
            base = TRACE_BASE + 4 * i;
            wait_commit(i);
            exp_data = test_mem[base + 3];
            check_word("commit_pc_o", commit_pc_o, test_mem[base]);
            check_word("commit_instr_o", commit_instr_o, test_mem[base + 1]);
            check_reg_idx("commit_rd_o", commit_rd_o, test_mem[base + 2][`RV_REG_IDX_W-1:0]);
            check_word("commit_data_o", commit_data_o, exp_data);
            if (test_mem[base + 2] == 32'd10) begin
                a0_pending  = 1'b1;
                a0_expected = exp_data;
            end
        end
        next_cycle();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verif/rv_core_assert.sv ====
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_core_assert (
    input logic                     clk,
    input logic                     reset_i,
    input logic                     sram_ren_i,
    input logic [`RV_XLEN-1:0]      sram_addr_i,
    input logic                     sram_valid_i,
    input logic                     commit_valid_i,
    input logic [`RV_REG_IDX_W-1:0] commit_rd_i,
    input logic                     wb_wr_en_i
);

    quiet_in_reset: assert property (@(posedge clk)
        reset_i && $past(reset_i) |-> !sram_ren_i && !commit_valid_i)
        else $error("fetch request or commit while in reset");

    // address held until the memory answers
    addr_held: assert property (@(posedge clk) disable iff (reset_i)
        sram_ren_i && !sram_valid_i |=> $stable(sram_addr_i))
        else $error("fetch address changed while a request was open");

    write_has_rd: assert property (@(posedge clk) disable iff (reset_i)
        commit_valid_i && wb_wr_en_i |-> commit_rd_i != '0)
        else $error("register write committed with rd zero");

endmodule

bind rv_core_top rv_core_assert rv_core_assert_bind (
    .clk            (clk),
    .reset_i        (reset_i),
    .sram_ren_i     (sram_ren_o),
    .sram_addr_i    (sram_addr_o),
    .sram_valid_i   (sram_data_valid_i),
    .commit_valid_i (commit_valid_o),
    .commit_rd_i    (commit_rd_o),
    .wb_wr_en_i     (wb_wr_en)
);

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held over four rising edges
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clk_o);
        #10;
        reset_o = 1'b0;
    end

endmodule

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ns
`include "rv_defs.svh"

module rv_core_top (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [`RV_ILEN-1:0]        sram_rdata_i,
    input  logic                       sram_data_valid_i,
    output logic [`RV_XLEN-1:0]        sram_addr_o,
    output logic                       sram_ren_o,
    output logic                       commit_valid_o,
    output logic [`RV_XLEN-1:0]        commit_pc_o,
    output logic [`RV_ILEN-1:0]        commit_instr_o,
    output logic [`RV_REG_IDX_W-1:0]   commit_rd_o,
    output logic [`RV_XLEN-1:0]        commit_data_o,
    output logic [`RV_XLEN-1:0]        reg_a0_o
);

    logic                       if_valid;
    logic [`RV_XLEN-1:0]        if_pc;
    logic [`RV_ILEN-1:0]        if_instr;
    logic                       id_valid;
    logic [`RV_XLEN-1:0]        id_pc;
    logic [`RV_ILEN-1:0]        id_instr;
    logic [`RV_XLEN-1:0]        rs1_val;
    logic [`RV_XLEN-1:0]        rs2_val;
    logic [`RV_REG_IDX_W-1:0]   rs1_idx;
    logic [`RV_REG_IDX_W-1:0]   rs2_idx;
    logic [`RV_XLEN-1:0]        imm;
    rv_isa_pkg::alu_op_e        alu_op;
    rv_isa_pkg::br_op_e         br_op;
    rv_isa_pkg::jump_kind_e     jump_kind;
    logic                       wr_en;
    logic                       redirect;
    logic [`RV_XLEN-1:0]        redirect_pc;
    logic                       wb_wr_en;

    fetch_stage u_fetch (
        .clk               (clk),
        .reset_i           (reset_i),
        .sram_rdata_i      (sram_rdata_i),
        .sram_data_valid_i (sram_data_valid_i),
        .redirect_i        (redirect),
        .redirect_pc_i     (redirect_pc),
        .sram_addr_o       (sram_addr_o),
        .sram_ren_o        (sram_ren_o),
        .if_valid_o        (if_valid),
        .if_pc_o           (if_pc),
        .if_instr_o        (if_instr)
    );

    // writeback fields feed the register file and the trace port
    decode_stage u_decode (
        .clk         (clk),
        .reset_i     (reset_i),
        .if_valid_i  (if_valid),
        .if_pc_i     (if_pc),
        .if_instr_i  (if_instr),
        .flush_i     (redirect),
        .wb_wr_en_i  (wb_wr_en),
        .wb_rd_i     (commit_rd_o),
        .wb_data_i   (commit_data_o),
        .id_valid_o  (id_valid),
        .id_pc_o     (id_pc),
        .id_instr_o  (id_instr),
        .rs1_val_o   (rs1_val),
        .rs2_val_o   (rs2_val),
        .rs1_idx_o   (rs1_idx),
        .rs2_idx_o   (rs2_idx),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .br_op_o     (br_op),
        .jump_kind_o (jump_kind),
        .wr_en_o     (wr_en),
        .reg_a0_o    (reg_a0_o)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .id_valid_i    (id_valid),
        .id_pc_i       (id_pc),
        .id_instr_i    (id_instr),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .rs1_idx_i     (rs1_idx),
        .rs2_idx_i     (rs2_idx),
        .imm_i         (imm),
        .alu_op_i      (alu_op),
        .br_op_i       (br_op),
        .jump_kind_i   (jump_kind),
        .wr_en_i       (wr_en),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_valid_o    (commit_valid_o),
        .wb_pc_o       (commit_pc_o),
        .wb_instr_o    (commit_instr_o),
        .wb_rd_o       (commit_rd_o),
        .wb_data_o     (commit_data_o),
        .wb_wr_en_o    (wb_wr_en)
    );

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ns
`include "rv_defs.svh"

module execute_stage (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       id_valid_i,
    input  logic [`RV_XLEN-1:0]        id_pc_i,
    input  logic [`RV_ILEN-1:0]        id_instr_i,
    input  logic [`RV_XLEN-1:0]        rs1_val_i,
    input  logic [`RV_XLEN-1:0]        rs2_val_i,
    input  logic [`RV_REG_IDX_W-1:0]   rs1_idx_i,
    input  logic [`RV_REG_IDX_W-1:0]   rs2_idx_i,
    input  logic [`RV_XLEN-1:0]        imm_i,
    input  rv_isa_pkg::alu_op_e        alu_op_i,
    input  rv_isa_pkg::br_op_e         br_op_i,
    input  rv_isa_pkg::jump_kind_e     jump_kind_i,
    input  logic                       wr_en_i,
    output logic                       redirect_o,
    output logic [`RV_XLEN-1:0]        redirect_pc_o,
    output logic                       wb_valid_o,
    output logic [`RV_XLEN-1:0]        wb_pc_o,
    output logic [`RV_ILEN-1:0]        wb_instr_o,
    output logic [`RV_REG_IDX_W-1:0]   wb_rd_o,
    output logic [`RV_XLEN-1:0]        wb_data_o,
    output logic                       wb_wr_en_o
);

    rv_pipe_pkg::fwd_sel_e rs1_sel;
    rv_pipe_pkg::fwd_sel_e rs2_sel;
    logic                  wb_hit;
    logic [`RV_XLEN-1:0]   op_a;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   alu_b;
    logic [`RV_XLEN-1:0]   alu_res;
    logic [`RV_XLEN-1:0]   result;
    logic                  taken;

    // forward from the writeback slot
    assign wb_hit  = wb_valid_o && wb_wr_en_o && (wb_rd_o != '0);
    assign rs1_sel = rv_pipe_pkg::fwd_sel_e'(wb_hit && (wb_rd_o == rs1_idx_i));
    assign rs2_sel = rv_pipe_pkg::fwd_sel_e'(wb_hit && (wb_rd_o == rs2_idx_i));
    assign op_a    = (rs1_sel == rv_pipe_pkg::FWD_WB) ? wb_data_o : rs1_val_i;
    assign op_b    = (rs2_sel == rv_pipe_pkg::FWD_WB) ? wb_data_o : rs2_val_i;

    // register-register ops take rs2, the rest the immediate
    assign alu_b = (id_instr_i[6:0] == rv_isa_pkg::OPC_OP) ? op_b : imm_i;

    always_comb begin
        case (alu_op_i)
            rv_isa_pkg::ALU_SUB:    alu_res = op_a - alu_b;
            rv_isa_pkg::ALU_AND:    alu_res = op_a & alu_b;
            rv_isa_pkg::ALU_OR:     alu_res = op_a | alu_b;
            rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ alu_b;
            rv_isa_pkg::ALU_SLT:    alu_res = `RV_XLEN'($signed(op_a) < $signed(alu_b));
            rv_isa_pkg::ALU_PASS_B: alu_res = alu_b;
            default:                alu_res = op_a + alu_b;
        endcase
    end

    always_comb begin
        case (br_op_i)
            rv_isa_pkg::BR_EQ: taken = (op_a == op_b);
            rv_isa_pkg::BR_NE: taken = (op_a != op_b);
            rv_isa_pkg::BR_LT: taken = ($signed(op_a) < $signed(op_b));
            default:           taken = 1'b0;
        endcase
    end

    // link value for jumps
    assign result = (jump_kind_i != rv_isa_pkg::JMP_NONE) ? id_pc_i + `RV_XLEN'(4) : alu_res;

    assign redirect_o    = id_valid_i && (taken || (jump_kind_i != rv_isa_pkg::JMP_NONE));
    assign redirect_pc_o = (jump_kind_i == rv_isa_pkg::JMP_JALR) ?
                           ((op_a + imm_i) & ~`RV_XLEN'(1)) : id_pc_i + imm_i;

    // execute/writeback register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_wr_en_o <= 1'b0;
        end else begin
            wb_valid_o <= id_valid_i;
            wb_wr_en_o <= id_valid_i && wr_en_i;
        end
    end

    // no-write slots carry rd and data as zero
    always_ff @(posedge clk) begin
        wb_pc_o    <= id_pc_i;
        wb_instr_o <= id_instr_i;
        wb_rd_o    <= wr_en_i ? id_instr_i[11:7] : '0;
        wb_data_o  <= wr_en_i ? result : '0;
    end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ns
`include "rv_defs.svh"

module decode_stage (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       if_valid_i,
    input  logic [`RV_XLEN-1:0]        if_pc_i,
    input  logic [`RV_ILEN-1:0]        if_instr_i,
    input  logic                       flush_i,
    input  logic                       wb_wr_en_i,
    input  logic [`RV_REG_IDX_W-1:0]   wb_rd_i,
    input  logic [`RV_XLEN-1:0]        wb_data_i,
    output logic                       id_valid_o,
    output logic [`RV_XLEN-1:0]        id_pc_o,
    output logic [`RV_ILEN-1:0]        id_instr_o,
    output logic [`RV_XLEN-1:0]        rs1_val_o,
    output logic [`RV_XLEN-1:0]        rs2_val_o,
    output logic [`RV_REG_IDX_W-1:0]   rs1_idx_o,
    output logic [`RV_REG_IDX_W-1:0]   rs2_idx_o,
    output logic [`RV_XLEN-1:0]        imm_o,
    output rv_isa_pkg::alu_op_e        alu_op_o,
    output rv_isa_pkg::br_op_e         br_op_o,
    output rv_isa_pkg::jump_kind_e     jump_kind_o,
    output logic                       wr_en_o,
    output logic [`RV_XLEN-1:0]        reg_a0_o
);

    logic [`RV_XLEN-1:0]       regs [`RV_NUM_REGS];
    rv_isa_pkg::opcode_e       opcode;
    logic [2:0]                funct3;
    logic [`RV_REG_IDX_W-1:0]  rs1_idx;
    logic [`RV_REG_IDX_W-1:0]  rs2_idx;
    logic [`RV_REG_IDX_W-1:0]  rd_idx;
    logic [`RV_XLEN-1:0]       i_imm;
    logic [`RV_XLEN-1:0]       b_imm;
    logic [`RV_XLEN-1:0]       u_imm;
    logic [`RV_XLEN-1:0]       j_imm;
    logic [`RV_XLEN-1:0]       imm;
    logic [`RV_XLEN-1:0]       rs1_val;
    logic [`RV_XLEN-1:0]       rs2_val;
    rv_isa_pkg::alu_op_e       alu_op;
    rv_isa_pkg::br_op_e        br_op;
    rv_isa_pkg::jump_kind_e    jump_kind;
    logic                      wr_en;

    assign opcode  = rv_isa_pkg::opcode_e'(if_instr_i[6:0]);
    assign funct3  = if_instr_i[14:12];
    assign rs1_idx = if_instr_i[19:15];
    assign rs2_idx = if_instr_i[24:20];
    assign rd_idx  = if_instr_i[11:7];

    assign i_imm = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign b_imm = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};
    assign u_imm = {if_instr_i[31:12], 12'b0};
    assign j_imm = {{11{if_instr_i[31]}}, if_instr_i[31], if_instr_i[19:12],
                    if_instr_i[20], if_instr_i[30:21], 1'b0};

    always_comb begin
        alu_op    = rv_isa_pkg::ALU_ADD;
        br_op     = rv_isa_pkg::BR_NONE;
        jump_kind = rv_isa_pkg::JMP_NONE;
        wr_en     = 1'b0;
        imm       = i_imm;
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM: begin
                wr_en = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: alu_op = rv_isa_pkg::ALU_ADD;
                    rv_isa_pkg::F3_XOR:     alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:      alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     alu_op = rv_isa_pkg::ALU_AND;
                    default:                wr_en  = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_OP: begin
                wr_en = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        if (if_instr_i[30]) begin
                            alu_op = rv_isa_pkg::ALU_SUB;
                        end
                    end
                    rv_isa_pkg::F3_SLT: alu_op = rv_isa_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: alu_op = rv_isa_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:  alu_op = rv_isa_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: alu_op = rv_isa_pkg::ALU_AND;
                    default:            wr_en  = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LUI: begin
                alu_op = rv_isa_pkg::ALU_PASS_B;
                imm    = u_imm;
                wr_en  = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                imm = b_imm;
                case (funct3)
                    rv_isa_pkg::F3_BEQ: br_op = rv_isa_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE: br_op = rv_isa_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT: br_op = rv_isa_pkg::BR_LT;
                    default:            br_op = rv_isa_pkg::BR_NONE;
                endcase
            end
            rv_isa_pkg::OPC_JAL: begin
                jump_kind = rv_isa_pkg::JMP_JAL;
                imm       = j_imm;
                wr_en     = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                jump_kind = rv_isa_pkg::JMP_JALR;
                wr_en     = 1'b1;
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
        // x0 is never written
        if (rd_idx == '0) begin
            wr_en = 1'b0;
        end
    end

    // write-through read, x0 reads zero
    assign rs1_val = (rs1_idx == '0) ? '0 :
                     (wb_wr_en_i && (wb_rd_i == rs1_idx)) ? wb_data_i : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 :
                     (wb_wr_en_i && (wb_rd_i == rs2_idx)) ? wb_data_i : regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (wb_wr_en_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    assign reg_a0_o = regs[10];

    // decode/execute register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= if_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        id_pc_o     <= if_pc_i;
        id_instr_o  <= if_instr_i;
        rs1_val_o   <= rs1_val;
        rs2_val_o   <= rs2_val;
        rs1_idx_o   <= rs1_idx;
        rs2_idx_o   <= rs2_idx;
        imm_o       <= imm;
        alu_op_o    <= alu_op;
        br_op_o     <= br_op;
        jump_kind_o <= jump_kind;
        wr_en_o     <= wr_en;
    end

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ns
`include "rv_defs.svh"

module fetch_stage (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [`RV_ILEN-1:0] sram_rdata_i,
    input  logic                sram_data_valid_i,
    input  logic                redirect_i,
    input  logic [`RV_XLEN-1:0] redirect_pc_i,
    output logic [`RV_XLEN-1:0] sram_addr_o,
    output logic                sram_ren_o,
    output logic                if_valid_o,
    output logic [`RV_XLEN-1:0] if_pc_o,
    output logic [`RV_ILEN-1:0] if_instr_o
);

    rv_pipe_pkg::fetch_state_e state_q;
    logic [`RV_XLEN-1:0]       pc_q;
    logic [`RV_XLEN-1:0]       target_q;
    logic                      accept;

    // pc_q stays put until the memory answers
    assign sram_addr_o = pc_q;
    assign sram_ren_o  = (state_q != rv_pipe_pkg::FS_WAIT);
    assign accept      = (state_q == rv_pipe_pkg::FS_REQ) && sram_data_valid_i && !redirect_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= rv_pipe_pkg::FS_WAIT;
            pc_q    <= `RV_RESET_PC;
        end else begin
            case (state_q)
                rv_pipe_pkg::FS_WAIT: begin
                    state_q <= rv_pipe_pkg::FS_REQ;
                end
                rv_pipe_pkg::FS_REQ: begin
                    if (redirect_i && !sram_data_valid_i) begin
                        // answer still pending for the old address
                        state_q <= rv_pipe_pkg::FS_DROP;
                    end else if (redirect_i) begin
                        pc_q <= redirect_pc_i;
                    end else if (sram_data_valid_i) begin
                        pc_q <= pc_q + `RV_XLEN'(4);
                    end
                end
                rv_pipe_pkg::FS_DROP: begin
                    if (sram_data_valid_i) begin
                        state_q <= rv_pipe_pkg::FS_REQ;
                        pc_q    <= target_q;
                    end
                end
                default: begin
                    state_q <= rv_pipe_pkg::FS_WAIT;
                end
            endcase
        end
    end

    // redirect target, used on leaving FS_DROP
    always_ff @(posedge clk) begin
        if (redirect_i) begin
            target_q <= redirect_pc_i;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            if_valid_o <= 1'b0;
        end else begin
            if_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if_pc_o    <= pc_q;
            if_instr_o <= sram_rdata_i;
        end
    end

endmodule

// ==== logic/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // FS_WAIT is the idle state out of reset, no request
    typedef enum logic [1:0] {
        FS_WAIT,
        FS_REQ,
        FS_DROP
    } fetch_state_e;

    // operand source in execute
    typedef enum logic {
        FWD_REG,
        FWD_WB
    } fwd_sel_e;

endpackage

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT
    } br_op_e;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_JAL,
        JMP_JALR
    } jump_kind_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;

endpackage

// ==== logic/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN       32
`define RV_ILEN       32
`define RV_REG_IDX_W  5
`define RV_NUM_REGS   32
`define RV_RESET_PC   32'h0000_0000

`endif
